/* hdl/memBusPkg.sv */
package memBusPkg;

    // processor side
    localparam int ADDR_W = 32;
    localparam int WORD_W = 32;

    // ram side is one byte wide
    localparam int MEM_W = 8;

    // bytes per word
    localparam int NUM_LANES = WORD_W / MEM_W;

    // lane index width
    localparam int LANE_W = $clog2(NUM_LANES);

    typedef logic [ADDR_W-1:0] addr_t;

    typedef logic [MEM_W-1:0] memByte_t;

    typedef logic [WORD_W-1:0] word_t;

endpackage

/* hdl/memCtrlPkg.sv */
package memCtrlPkg;

    // kind of the transaction in flight
    typedef enum logic [1:0] {
        TX_IDLE  = 2'd0,
        TX_FETCH = 2'd1,
        TX_LOAD  = 2'd2,
        TX_STORE = 2'd3
    } txKind_t;

    // access length in bytes with lsb first at consecutive addresses
    typedef enum logic [2:0] {
        LEN_BYTE = 3'd1,
        LEN_HALF = 3'd2,
        LEN_WORD = 3'd4
    } len_t;

    // i_dcLs level that selects a store
    localparam logic LS_STORE = 1'b1;

    typedef enum logic [1:0] {
        SEQ_IDLE  = 2'd0,
        SEQ_ADDR  = 2'd1,
        SEQ_DRAIN = 2'd2,
        SEQ_DONE  = 2'd3
    } seqState_t;

endpackage

/* hdl/laneIf.sv */
`timescale 1ns/100ps

interface laneIf;

    // global stall from the top level
    logic stall;

    // pulses in the cycle a transaction is accepted
    logic clear;

    // store data or zero for reads
    memBusPkg::word_t storeWord;

    // one bit per lane
    logic [memBusPkg::NUM_LANES-1:0] capture;

    memBusPkg::memByte_t rdByte;

    memBusPkg::memByte_t laneByte [memBusPkg::NUM_LANES];

    modport seq (
        output clear,
        output storeWord,
        output capture,
        output rdByte,
        input  laneByte
    );

    modport lane (
        input  stall,
        input  clear,
        input  storeWord,
        input  capture,
        input  rdByte,
        output laneByte
    );

    modport fmt (
        input laneByte
    );

endinterface

/* hdl/memSequencer.sv */
`timescale 1ns/100ps

module memSequencer (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 i_stall,

    input  logic                 i_infEn,
    input  memBusPkg::addr_t     i_infAddr,

    input  logic                 i_dcEn,
    input  logic                 i_dcLs,
    input  memCtrlPkg::len_t     i_dcLen,
    input  memBusPkg::addr_t     i_dcAddr,
    input  memBusPkg::word_t     i_dcData,

    input  memBusPkg::memByte_t  i_memData,
    output logic                 o_memRw,
    output memBusPkg::addr_t     o_memAddr,
    output memBusPkg::memByte_t  o_memData,

    laneIf.seq                   lanes,

    output memCtrlPkg::txKind_t  o_doneKind,
    output memCtrlPkg::len_t     o_doneLen
);

    memCtrlPkg::seqState_t state;
    memCtrlPkg::txKind_t   kindQ;
    memCtrlPkg::len_t      lenQ;
    memBusPkg::addr_t      addrQ;
    memBusPkg::addr_t      lastAddr;
    logic [memBusPkg::LANE_W-1:0] count;
    logic [memBusPkg::LANE_W-1:0] lastIdx;
    logic [memBusPkg::LANE_W-1:0] pendIdx;
    logic                  pendValid;
    logic                  lastByte;
    logic                  accept;

    memCtrlPkg::txKind_t   acceptKind;
    memBusPkg::addr_t      acceptAddr;
    memCtrlPkg::len_t      acceptLen;

    // data side wins over fetch
    always_comb begin
        acceptKind = memCtrlPkg::TX_IDLE;
        acceptAddr = i_infAddr;
        acceptLen  = memCtrlPkg::LEN_WORD;
        if (i_dcEn) begin
            if (i_dcLs == memCtrlPkg::LS_STORE) begin
                acceptKind = memCtrlPkg::TX_STORE;
            end else begin
                acceptKind = memCtrlPkg::TX_LOAD;
            end
            acceptAddr = i_dcAddr;
            acceptLen  = i_dcLen;
        end else if (i_infEn) begin
            acceptKind = memCtrlPkg::TX_FETCH;
        end
    end

    assign accept = (state == memCtrlPkg::SEQ_IDLE)
                 && (acceptKind != memCtrlPkg::TX_IDLE)
                 && !i_stall;

    assign lastIdx  = memBusPkg::LANE_W'(lenQ - 3'd1);
    assign lastByte = (count == lastIdx);

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= memCtrlPkg::SEQ_IDLE;
            kindQ     <= memCtrlPkg::TX_IDLE;
            lenQ      <= memCtrlPkg::LEN_WORD;
            addrQ     <= '0;
            lastAddr  <= '0;
            count     <= '0;
            pendValid <= 1'b0;
            pendIdx   <= '0;
        end else if (!i_stall) begin
            lastAddr  <= addrQ;
            pendValid <= 1'b0;
            case (state)
                memCtrlPkg::SEQ_IDLE: begin
                    if (accept) begin
                        state <= memCtrlPkg::SEQ_ADDR;
                        kindQ <= acceptKind;
                        lenQ  <= acceptLen;
                        addrQ <= acceptAddr;
                        count <= '0;
                    end
                end
                memCtrlPkg::SEQ_ADDR: begin
                    addrQ <= addrQ + 1'b1;
                    count <= count + 1'b1;
                    // read byte for this lane comes back next cycle
                    pendValid <= (kindQ != memCtrlPkg::TX_STORE);
                    pendIdx   <= count;
                    if (lastByte) begin
                        if (kindQ == memCtrlPkg::TX_STORE) begin
                            state <= memCtrlPkg::SEQ_DONE;
                        end else begin
                            state <= memCtrlPkg::SEQ_DRAIN;
                        end
                    end
                end
                memCtrlPkg::SEQ_DRAIN: begin
                    state <= memCtrlPkg::SEQ_DONE;
                end
                default: begin
                    state <= memCtrlPkg::SEQ_IDLE;
                    kindQ <= memCtrlPkg::TX_IDLE;
                end
            endcase
        end
    end

    // re-issue the last unstalled address so a pending read byte
    // is still on i_memData when the stall ends
    assign o_memAddr = i_stall ? lastAddr : addrQ;

    assign o_memRw = (state == memCtrlPkg::SEQ_ADDR)
                  && (kindQ == memCtrlPkg::TX_STORE)
                  && !i_stall;

    assign o_memData = lanes.laneByte[count];

    assign lanes.clear   = accept;
    assign lanes.rdByte  = i_memData;
    // reads preload zeros, which gives the zero extension
    assign lanes.storeWord = (acceptKind == memCtrlPkg::TX_STORE) ? i_dcData : '0;
    assign lanes.capture = pendValid
                         ? ({{(memBusPkg::NUM_LANES-1){1'b0}}, 1'b1} << pendIdx)
                         : '0;

    // formatter registers this into the done pulse
    always_comb begin
        o_doneKind = memCtrlPkg::TX_IDLE;
        if (state == memCtrlPkg::SEQ_DRAIN) begin
            o_doneKind = kindQ;
        end else if ((state == memCtrlPkg::SEQ_ADDR) && lastByte
                     && (kindQ == memCtrlPkg::TX_STORE)) begin
            o_doneKind = kindQ;
        end
    end

    assign o_doneLen = lenQ;

    assert property (@(posedge clk) disable iff (rst)
        accept |-> (acceptLen inside {memCtrlPkg::LEN_BYTE, memCtrlPkg::LEN_HALF,
                                      memCtrlPkg::LEN_WORD}));

endmodule

/* hdl/byteLane.sv */
`timescale 1ns/100ps

module byteLane #(
    parameter int LANE = 0
) (
    input  logic clk,
    input  logic rst,
    laneIf.lane  lanes
);

    memBusPkg::memByte_t byteQ;
    logic                captured;

    always_ff @(posedge clk) begin
        if (rst) begin
            byteQ    <= '0;
            captured <= 1'b0;
        end else if (!lanes.stall) begin
            if (lanes.clear) begin
                // store byte or zero for a read
                byteQ    <= lanes.storeWord[LANE*memBusPkg::MEM_W +: memBusPkg::MEM_W];
                captured <= 1'b0;
            end else if (lanes.capture[LANE]) begin
                byteQ    <= lanes.rdByte;
                captured <= 1'b1;
            end
        end
    end

    // lanes past the access length keep their zero
    assign lanes.laneByte[LANE] = byteQ;

    // one returning byte per lane per transaction
    assert property (@(posedge clk) disable iff (rst)
        (lanes.capture[LANE] && !lanes.stall) |-> !captured);

endmodule

/* hdl/resultFormatter.sv */
`timescale 1ns/100ps

module resultFormatter (
    input  logic                clk,
    input  logic                rst,
    input  logic                i_stall,

    input  memCtrlPkg::txKind_t i_doneKind,
    input  memCtrlPkg::len_t    i_doneLen,

    laneIf.fmt                  lanes,

    output logic                o_infDone,
    output memBusPkg::word_t    o_infInst,

    output logic                o_bpEn,
    output memBusPkg::word_t    o_bpInst,

    output logic                o_dcDone,
    output memBusPkg::word_t    o_dcData
);

    logic             infPend;
    logic             dcPend;
    memBusPkg::word_t laneWord;

    // lane 0 is the least significant byte
    always_comb begin
        for (int k = 0; k < memBusPkg::NUM_LANES; k++) begin
            laneWord[k*memBusPkg::MEM_W +: memBusPkg::MEM_W] = lanes.laneByte[k];
        end
    end

    // pending pulse holds through a stall
    always_ff @(posedge clk) begin
        if (rst) begin
            infPend <= 1'b0;
            dcPend  <= 1'b0;
        end else if (!i_stall) begin
            infPend <= (i_doneKind == memCtrlPkg::TX_FETCH);
            dcPend  <= (i_doneKind == memCtrlPkg::TX_LOAD)
                    || (i_doneKind == memCtrlPkg::TX_STORE);
        end
    end

    assign o_infDone = infPend && !i_stall;
    assign o_infInst = o_infDone ? laneWord : '0;

    // predictor gets its own copy of every fetch
    assign o_bpEn   = o_infDone;
    assign o_bpInst = o_infInst;

    assign o_dcDone = dcPend && !i_stall;
    assign o_dcData = o_dcDone ? laneWord : '0;

    // fetch results are only formatted from full words
    assert property (@(posedge clk) disable iff (rst)
        (i_doneKind == memCtrlPkg::TX_FETCH) |-> (i_doneLen == memCtrlPkg::LEN_WORD));

endmodule

/* hdl/memCtrl.sv */
`timescale 1ns/100ps

module memCtrl (
    input  logic                clk,
    input  logic                rst,
    input  logic                i_rdy,
    input  logic                i_ioBufferFull,

    // ram
    input  memBusPkg::memByte_t i_memData,
    output logic                o_memRw,
    output memBusPkg::addr_t    o_memAddr,
    output memBusPkg::memByte_t o_memData,

    // instruction fetch
    input  logic                i_infEn,
    input  memBusPkg::addr_t    i_infAddr,
    output logic                o_infDone,
    output memBusPkg::word_t    o_infInst,

    // branch predictor copy
    output logic                o_bpEn,
    output memBusPkg::word_t    o_bpInst,

    // data load/store
    input  logic                i_dcEn,
    input  logic                i_dcLs,
    input  memCtrlPkg::len_t    i_dcLen,
    input  memBusPkg::word_t    i_dcData,
    input  memBusPkg::addr_t    i_dcAddr,
    output logic                o_dcDone,
    output memBusPkg::word_t    o_dcData
);

    logic                stall;
    memCtrlPkg::txKind_t doneKind;
    memCtrlPkg::len_t    doneLen;

    laneIf laneBus ();

    // frozen while the io buffer is full or the core is not ready
    assign stall = i_ioBufferFull || !i_rdy;
    assign laneBus.stall = stall;

    memSequencer u_seq (
        .clk        (clk),
        .rst        (rst),
        .i_stall    (stall),
        .i_infEn    (i_infEn),
        .i_infAddr  (i_infAddr),
        .i_dcEn     (i_dcEn),
        .i_dcLs     (i_dcLs),
        .i_dcLen    (i_dcLen),
        .i_dcAddr   (i_dcAddr),
        .i_dcData   (i_dcData),
        .i_memData  (i_memData),
        .o_memRw    (o_memRw),
        .o_memAddr  (o_memAddr),
        .o_memData  (o_memData),
        .lanes      (laneBus.seq),
        .o_doneKind (doneKind),
        .o_doneLen  (doneLen)
    );

    for (genvar g = 0; g < memBusPkg::NUM_LANES; g++) begin : g_lane
        byteLane #(
            .LANE (g)
        ) u_lane (
            .clk   (clk),
            .rst   (rst),
            .lanes (laneBus.lane)
        );
    end

    resultFormatter u_fmt (
        .clk        (clk),
        .rst        (rst),
        .i_stall    (stall),
        .i_doneKind (doneKind),
        .i_doneLen  (doneLen),
        .lanes      (laneBus.fmt),
        .o_infDone  (o_infDone),
        .o_infInst  (o_infInst),
        .o_bpEn     (o_bpEn),
        .o_bpInst   (o_bpInst),
        .o_dcDone   (o_dcDone),
        .o_dcData   (o_dcData)
    );

endmodule

/* sim/ramModel.sv */
`timescale 1ns/100ps

module ramModel #(
    parameter int DEPTH = 256
) (
    input  logic                clk,
    input  logic                i_rw,
    input  memBusPkg::addr_t    i_addr,
    input  memBusPkg::memByte_t i_data,
    output memBusPkg::memByte_t o_data
);

    localparam int AW = $clog2(DEPTH);

    // filled from the testbench at time zero
    memBusPkg::memByte_t mem [DEPTH];

    initial o_data = '0;

    // registered read, so data follows its address by one cycle
    always @(posedge clk) begin
        if (i_rw) begin
            mem[i_addr[AW-1:0]] <= i_data;
        end
        o_data <= mem[i_addr[AW-1:0]];
    end

endmodule

/* sim/memCtrl_tb.sv */
`timescale 1ns/100ps

module memCtrl_tb;

    localparam int PERIOD     = 20;
    localparam int RST_CYCLES = 5;
    localparam int RAM_DEPTH  = 256;
    localparam int NUM_ROWS   = 17;
    localparam int FETCH_LAT  = int'(memCtrlPkg::LEN_WORD) + 2;
    localparam int TIMEOUT_CYCLES = RST_CYCLES + NUM_ROWS * 20;

    typedef struct {
        memCtrlPkg::txKind_t kind;
        int                  addr;
        memCtrlPkg::len_t    len;
        bit                  withFetch;
        bit                  stallOn;
        int                  lat;
        memBusPkg::word_t    data;
    } row_t;

    logic                clk = 1'b0;
    logic                rst;
    logic                rdy;
    logic                ioBufferFull;
    memBusPkg::memByte_t memRdata;
    logic                memRw;
    memBusPkg::addr_t    memAddr;
    memBusPkg::memByte_t memWdata;
    logic                infEn;
    memBusPkg::addr_t    infAddr;
    logic                infDone;
    memBusPkg::word_t    infInst;
    logic                bpEn;
    memBusPkg::word_t    bpInst;
    logic                dcEn;
    logic                dcLs;
    memCtrlPkg::len_t    dcLen;
    memBusPkg::word_t    dcWdata;
    memBusPkg::addr_t    dcAddr;
    logic                dcDone;
    memBusPkg::word_t    dcRdata;

    integer              seed = 32'h654f;
    int                  mismatches = 0;
    int                  otherErrors = 0;
    row_t                rows [NUM_ROWS];
    memBusPkg::memByte_t shadow [RAM_DEPTH];

    always #(PERIOD / 2) clk = ~clk;

    memCtrl u_memCtrl (
        .clk            (clk),
        .rst            (rst),
        .i_rdy          (rdy),
        .i_ioBufferFull (ioBufferFull),
        .i_memData      (memRdata),
        .o_memRw        (memRw),
        .o_memAddr      (memAddr),
        .o_memData      (memWdata),
        .i_infEn        (infEn),
        .i_infAddr      (infAddr),
        .o_infDone      (infDone),
        .o_infInst      (infInst),
        .o_bpEn         (bpEn),
        .o_bpInst       (bpInst),
        .i_dcEn         (dcEn),
        .i_dcLs         (dcLs),
        .i_dcLen        (dcLen),
        .i_dcData       (dcWdata),
        .i_dcAddr       (dcAddr),
        .o_dcDone       (dcDone),
        .o_dcData       (dcRdata)
    );

    ramModel #(
        .DEPTH (RAM_DEPTH)
    ) u_ram (
        .clk    (clk),
        .i_rw   (memRw),
        .i_addr (memAddr),
        .i_data (memWdata),
        .o_data (memRdata)
    );

    function automatic memBusPkg::memByte_t fillByte(input int a);
        return memBusPkg::MEM_W'(a * 37 + 90);
    endfunction

    // lsb first from the shadow with upper bytes zero
    function automatic memBusPkg::word_t expWord(input int base, input int len);
        memBusPkg::word_t w;
        w = '0;
        for (int k = 0; k < len; k++) begin
            w[k*memBusPkg::MEM_W +: memBusPkg::MEM_W] = shadow[base + k];
        end
        return w;
    endfunction

    task automatic checkVal(input string name, input logic [31:0] got, input logic [31:0] exp);
        assert (got === exp) else begin
            $display("Mismatch %s: got %h expected %h at %0t", name, got, exp, $time);
            mismatches++;
        end
    endtask

    task automatic checkCond(input bit cond, input string what);
        assert (cond) else begin
            $display("Error at %0t: %s", $time, what);
            otherErrors++;
        end
    endtask

    task automatic driveStall(input bit enable);
        logic [31:0] rnd;
        rnd = $random(seed);
        rdy          <= !(enable && rnd[2:0] == 3'd0);
        ioBufferFull <= enable && (rnd[6:4] == 3'd0);
    endtask

    // kind, address, length, fetch alongside, stall, done latency
    task automatic loadTable();
        rows[0]  = '{memCtrlPkg::TX_FETCH, 'h10, memCtrlPkg::LEN_WORD, 0, 0, 6, '0};
        rows[1]  = '{memCtrlPkg::TX_LOAD,  'h21, memCtrlPkg::LEN_BYTE, 0, 0, 3, '0};
        rows[2]  = '{memCtrlPkg::TX_LOAD,  'h22, memCtrlPkg::LEN_HALF, 0, 0, 4, '0};
        rows[3]  = '{memCtrlPkg::TX_STORE, 'h30, memCtrlPkg::LEN_BYTE, 0, 0, 2, '0};
        rows[4]  = '{memCtrlPkg::TX_STORE, 'h34, memCtrlPkg::LEN_HALF, 0, 0, 3, '0};
        rows[5]  = '{memCtrlPkg::TX_STORE, 'h38, memCtrlPkg::LEN_WORD, 0, 0, 5, '0};
        rows[6]  = '{memCtrlPkg::TX_LOAD,  'h30, memCtrlPkg::LEN_WORD, 0, 0, 6, '0};
        rows[7]  = '{memCtrlPkg::TX_LOAD,  'h34, memCtrlPkg::LEN_WORD, 0, 0, 6, '0};
        rows[8]  = '{memCtrlPkg::TX_LOAD,  'h38, memCtrlPkg::LEN_WORD, 0, 0, 6, '0};
        rows[9]  = '{memCtrlPkg::TX_STORE, 'h40, memCtrlPkg::LEN_WORD, 1, 0, 5, '0};
        rows[10] = '{memCtrlPkg::TX_LOAD,  'h80, memCtrlPkg::LEN_WORD, 1, 0, 6, '0};
        rows[11] = '{memCtrlPkg::TX_FETCH, 'h50, memCtrlPkg::LEN_WORD, 0, 1, 6, '0};
        rows[12] = '{memCtrlPkg::TX_STORE, 'h60, memCtrlPkg::LEN_WORD, 0, 1, 5, '0};
        rows[13] = '{memCtrlPkg::TX_LOAD,  'h60, memCtrlPkg::LEN_WORD, 0, 1, 6, '0};
        rows[14] = '{memCtrlPkg::TX_STORE, 'h71, memCtrlPkg::LEN_HALF, 1, 1, 3, '0};
        rows[15] = '{memCtrlPkg::TX_LOAD,  'h70, memCtrlPkg::LEN_WORD, 0, 1, 6, '0};
        rows[16] = '{memCtrlPkg::TX_LOAD,  'h72, memCtrlPkg::LEN_BYTE, 0, 1, 3, '0};
        for (int i = 0; i < NUM_ROWS; i++) begin
            rows[i].data = $random(seed);
        end
    endtask

    // latencies count unstalled cycles from the acceptance cycle
    task automatic runRow(input int r);
        row_t             row;
        bit               dataPending;
        bit               fetchPending;
        bit               accepted;
        bit               stalled;
        bit               fetchDue;
        int               cnt;
        int               fetchLat;
        memBusPkg::word_t want;
        row          = rows[r];
        dataPending  = (row.kind != memCtrlPkg::TX_FETCH);
        fetchPending = (row.kind == memCtrlPkg::TX_FETCH) || row.withFetch;
        fetchLat     = (row.kind == memCtrlPkg::TX_FETCH) ? row.lat : FETCH_LAT;
        accepted     = 1'b0;
        cnt          = 0;
        @(posedge clk);
        dcEn    <= dataPending;
        dcLs    <= (row.kind == memCtrlPkg::TX_STORE) ? memCtrlPkg::LS_STORE
                                                       : ~memCtrlPkg::LS_STORE;
        dcLen   <= row.len;
        dcAddr  <= memBusPkg::ADDR_W'(row.addr);
        dcWdata <= row.data;
        infEn   <= fetchPending;
        infAddr <= memBusPkg::ADDR_W'(row.addr);
        driveStall(row.stallOn);
        while (dataPending || fetchPending) begin
            @(negedge clk);
            stalled = !rdy || ioBufferFull;
            if (stalled) begin
                checkVal("o_memRw", memRw, 0);
            end else begin
                if (accepted) begin
                    cnt++;
                end else begin
                    accepted = 1'b1;
                    cnt      = 0;
                end
                if (dataPending && row.kind == memCtrlPkg::TX_STORE
                        && cnt >= 1 && cnt <= int'(row.len)) begin
                    checkVal("o_memRw", memRw, 1);
                    checkVal("o_memAddr", memAddr, row.addr + cnt - 1);
                    checkVal("o_memData", memWdata,
                             row.data[(cnt-1)*memBusPkg::MEM_W +: memBusPkg::MEM_W]);
                end else begin
                    checkVal("o_memRw", memRw, 0);
                end
            end
            // predictor strobe only in the cycle the fetch is due
            fetchDue = !stalled && accepted && fetchPending && !dataPending
                    && (cnt == fetchLat);
            checkVal("o_bpEn", bpEn, fetchDue);
            if (dcDone) begin
                checkCond(dataPending, "data done pulse without a pending data request");
                checkCond(cnt == row.lat, $sformatf("data done after %0d cycles, expected %0d",
                                                    cnt, row.lat));
                if (row.kind == memCtrlPkg::TX_LOAD) begin
                    checkVal("o_dcData", dcRdata, expWord(row.addr, row.len));
                end else begin
                    for (int k = 0; k < int'(row.len); k++) begin
                        shadow[row.addr + k] = row.data[k*memBusPkg::MEM_W +: memBusPkg::MEM_W];
                    end
                end
                dataPending = 1'b0;
                // a held fetch is accepted in the next unstalled cycle
                accepted    = 1'b0;
            end
            if (infDone) begin
                checkCond(fetchPending && !dataPending,
                          "fetch done pulse unexpected or ahead of the data done pulse");
                checkCond(cnt == fetchLat, $sformatf("fetch done after %0d cycles, expected %0d",
                                                     cnt, fetchLat));
                want = expWord(row.addr, int'(memCtrlPkg::LEN_WORD));
                checkVal("o_infInst", infInst, want);
                checkVal("o_bpInst", bpInst, want);
                fetchPending = 1'b0;
            end
            @(posedge clk);
            if (!dataPending) begin
                dcEn <= 1'b0;
            end
            if (!fetchPending) begin
                infEn <= 1'b0;
            end
            driveStall(row.stallOn && (dataPending || fetchPending));
        end
    endtask

    initial begin
        rst          = 1'b1;
        rdy          = 1'b1;
        ioBufferFull = 1'b0;
        infEn        = 1'b0;
        infAddr      = '0;
        dcEn         = 1'b0;
        dcLs         = 1'b0;
        dcLen        = memCtrlPkg::LEN_WORD;
        dcAddr       = '0;
        dcWdata      = '0;
        for (int a = 0; a < RAM_DEPTH; a++) begin
            shadow[a]    = fillByte(a);
            u_ram.mem[a] = shadow[a];
        end
        loadTable();
        repeat (RST_CYCLES) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        checkVal("o_memRw", memRw, 0);
        checkVal("o_infDone", infDone, 0);
        checkVal("o_bpEn", bpEn, 0);
        checkVal("o_dcDone", dcDone, 0);
        checkVal("o_memAddr", memAddr, 0);
        checkVal("o_infInst", infInst, 0);
        checkVal("o_bpInst", bpInst, 0);
        checkVal("o_dcData", dcRdata, 0);
        for (int r = 0; r < NUM_ROWS; r++) begin
            runRow(r);
        end
        repeat (2) @(posedge clk);
        $display("Summary: %0d mismatches, %0d other errors", mismatches, otherErrors);
        if (mismatches + otherErrors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

    // watchdog
    initial begin
        #(TIMEOUT_CYCLES * PERIOD);
        $display("Error: run timed out after %0d cycles", TIMEOUT_CYCLES);
        $display("Test failures found");
        $finish;
    end

endmodule

/* project.f */
hdl/memBusPkg.sv
hdl/memCtrlPkg.sv
hdl/laneIf.sv
hdl/memSequencer.sv
hdl/byteLane.sv
hdl/resultFormatter.sv
hdl/memCtrl.sv
sim/ramModel.sv
sim/memCtrl_tb.sv
